/* noc_mesh.f */
noc_pkg.sv
flit_fifo.sv
switch_alloc.sv
noc_router.sv
noc_mesh.sv
tb_clock.sv
noc_mesh_tb.sv

/* noc_mesh_tb.sv */
// ********************
// NoC mesh testbench
// ********************

`default_nettype none

module noc_mesh_tb import noc_pkg::*; ;
        timeunit 1ns;
        timeprecision 100ps;

        // Cycles allowed for any single wait
        localparam int WAIT_LIMIT = 5000;

        logic  clk;
        logic  rst_n;
        flit_t inj_data  [NODE_NUM];
        logic  inj_valid [NODE_NUM];
        logic  inj_ready [NODE_NUM];
        flit_t ej_data   [NODE_NUM];
        logic  ej_valid  [NODE_NUM];

        // Expected flits per source and destination
        flit_t exp_q  [NODE_NUM][NODE_NUM][$];
        // Flits waiting to be injected per source
        flit_t plan_q [NODE_NUM][$];

        logic [31:0] rng_state = 32'hf9963798;
        int          seq_cnt [NODE_NUM];
        int          sent_cnt = 0;
        int          recv_cnt = 0;
        // Cycles where a source was held off by inj_ready
        int          stall_cnt = 0;

        tb_clock clock_i (
                .clk   ( clk   ),
                .rst_n ( rst_n )
        );

        noc_mesh noc_mesh_i (
                .clk       ( clk       ),
                .rst_n     ( rst_n     ),
                .inj_data  ( inj_data  ),
                .inj_valid ( inj_valid ),
                .inj_ready ( inj_ready ),
                .ej_data   ( ej_data   ),
                .ej_valid  ( ej_valid  )
        );

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        // Row-major node that a flit must leave at
        function automatic int dest_node(input flit_t f);
                return int'(f.dst_y) * MESH_X + int'(f.dst_x);
        endfunction

        // Low payload bits carry source and sequence
        function automatic flit_t make_flit(input int src, input int dst);
                flit_t f;
                rng_state = xorshift(rng_state);
                f.dst_x   = COORD_W'(dst % MESH_X);
                f.dst_y   = COORD_W'(dst / MESH_X);
                f.payload = {rng_state[15:0], seq_cnt[src][7:0], src[3:0]};
                seq_cnt[src]++;
                return f;
        endfunction

        task automatic fail_run(input string msg);
                $display("%s", msg);
                $display("SIMULATION FAILED");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
                        fail_run("wrong value seen at the DUT outputs");
                end
        endtask

        // Enters and leaves on a falling edge
        task automatic send_flit(input int src, input flit_t f);
                int waited;
                inj_data[src]  = f;
                inj_valid[src] = 1'b1;
                exp_q[src][dest_node(f)].push_back(f);
                sent_cnt++;
                waited = 0;
                while (!inj_ready[src]) begin
                        if (waited >= WAIT_LIMIT) begin
                                fail_run($sformatf("node %0d never accepted an injection", src));
                        end else begin
                                @(negedge clk);
                                waited++;
                        end
                end
                // Taken at the rising edge in between
                @(negedge clk);
                inj_valid[src] = 1'b0;
        endtask

        task automatic wait_drain();
                int waited;
                waited = 0;
                while (recv_cnt != sent_cnt) begin
                        if (waited >= WAIT_LIMIT) begin
                                fail_run("flits still in flight when the wait ran out");
                        end else begin
                                @(negedge clk);
                                waited++;
                        end
                end
        endtask

        // Mode 0 is uniform random traffic
        // Mode 1 targets node 4 and mode 2 the source itself
        task automatic queue_traffic(input int mode, input int count);
                int dst;
                for (int s = 0; s < NODE_NUM; s++) begin
                        for (int k = 0; k < count; k++) begin
                                rng_state = xorshift(rng_state);
                                if (mode == 0) begin
                                        dst = int'(rng_state % NODE_NUM);
                                end else if (mode == 1) begin
                                        dst = 4;
                                end else begin
                                        dst = s;
                                end
                                plan_q[s].push_back(make_flit(s, dst));
                        end
                end
        endtask

        task automatic drain_source(input int src);
                while (plan_q[src].size() != 0) begin
                        send_flit(src, plan_q[src].pop_front());
                end
        endtask

        // All sources inject at once
        task automatic run_sources();
                for (int i = 0; i < NODE_NUM; i++) begin
                        fork
                                automatic int s = i;
                                drain_source(s);
                        join_none
                end
                wait fork;
                wait_drain();
        endtask

        // Back-pressure seen at the injection ports
        always @(negedge clk) begin
                if (rst_n) begin
                        for (int n = 0; n < NODE_NUM; n++) begin
                                if (inj_valid[n] && !inj_ready[n]) begin
                                        stall_cnt++;
                                end
                        end
                end
        end

        // Scoreboard samples ejection in the low phase
        always @(negedge clk) begin
                flit_t exp_flit;
                int    src;
                if (rst_n) begin
                        for (int n = 0; n < NODE_NUM; n++) begin
                                if (ej_valid[n]) begin
                                        src = int'(ej_data[n].payload[3:0]);
                                        if (src >= NODE_NUM || exp_q[src][n].size() == 0) begin
                                                fail_run($sformatf("unexpected flit at node %0d", n));
                                        end else begin
                                                exp_flit = exp_q[src][n].pop_front();
                                                check_value($sformatf("ej_data[%0d]", n),
                                                            ej_data[n], exp_flit);
                                                recv_cnt++;
                                        end
                                end
                        end
                end
        end

        initial begin
                int waited;
                int left;
                for (int n = 0; n < NODE_NUM; n++) begin
                        inj_data[n]  = '0;
                        inj_valid[n] = 1'b0;
                        seq_cnt[n]   = 0;
                end

                waited = 0;
                while (rst_n !== 1'b1) begin
                        if (waited >= 100) begin
                                fail_run("reset never released");
                        end else begin
                                @(negedge clk);
                                waited++;
                        end
                end

                // Idle state straight after reset
                for (int n = 0; n < NODE_NUM; n++) begin
                        check_value($sformatf("ej_valid[%0d]", n), ej_valid[n], 1'b0);
                        check_value($sformatf("inj_ready[%0d]", n), inj_ready[n], 1'b1);
                end

                // Every pair alone in the mesh
                for (int s = 0; s < NODE_NUM; s++) begin
                        for (int d = 0; d < NODE_NUM; d++) begin
                                send_flit(s, make_flit(s, d));
                                wait_drain();
                        end
                end

                queue_traffic(2, 4);
                run_sources();
                queue_traffic(0, 24);
                run_sources();
                // Ejection at node 4 saturates here
                stall_cnt = 0;
                queue_traffic(1, 16);
                run_sources();

                // Late duplicates would still show up
                repeat (20) @(negedge clk);
                left = 0;
                for (int s = 0; s < NODE_NUM; s++) begin
                        for (int d = 0; d < NODE_NUM; d++) begin
                                left += exp_q[s][d].size();
                        end
                end
                if (stall_cnt == 0) begin
                        fail_run("inj_ready never dropped under hotspot traffic");
                end else if (left != 0 || recv_cnt != sent_cnt) begin
                        fail_run($sformatf("%0d flits never delivered", left));
                end else begin
                        $display("SIMULATION PASSED");
                        $finish;
                end
        end

endmodule

`default_nettype wire

/* tb_clock.sv */
// ********************
// Testbench clock
// ********************

`default_nettype none

module tb_clock (
        output logic clk,
        output logic rst_n
);
        timeunit 1ns;
        timeprecision 100ps;

        // 100 ns period
        always #50 clk = ~clk;

        // Reset low for 16 cycles, released away from the edge
        initial begin
                clk   = 1'b0;
                rst_n = 1'b0;
                repeat (16) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
        end

endmodule

`default_nettype wire

/* noc_mesh.sv */
// ********************
// 3x3 mesh NoC
// ********************

`default_nettype none

module noc_mesh import noc_pkg::*; (
        input  logic  clk,
        input  logic  rst_n,

        // Local injection per node
        input  flit_t inj_data  [NODE_NUM],
        input  logic  inj_valid [NODE_NUM],
        output logic  inj_ready [NODE_NUM],

        // Local ejection per node, always accepted
        output flit_t ej_data   [NODE_NUM],
        output logic  ej_valid  [NODE_NUM]
);

        // Router side of every link, [node][port]
        flit_t rt_in_data   [NODE_NUM][PORT_NUM];
        logic  rt_in_valid  [NODE_NUM][PORT_NUM];
        logic  rt_in_ready  [NODE_NUM][PORT_NUM];
        flit_t rt_out_data  [NODE_NUM][PORT_NUM];
        logic  rt_out_valid [NODE_NUM][PORT_NUM];
        logic  rt_out_ready [NODE_NUM][PORT_NUM];

        for (genvar y = 0; y < MESH_Y; y++) begin : gen_y
                for (genvar x = 0; x < MESH_X; x++) begin : gen_x

                        // Local port, ejection ack tied high
                        assign rt_in_data[node_idx(x, y)][PORT_LOCAL]   = inj_data[node_idx(x, y)];
                        assign rt_in_valid[node_idx(x, y)][PORT_LOCAL]  = inj_valid[node_idx(x, y)];
                        assign inj_ready[node_idx(x, y)] = rt_in_ready[node_idx(x, y)][PORT_LOCAL];
                        assign ej_data[node_idx(x, y)]   = rt_out_data[node_idx(x, y)][PORT_LOCAL];
                        assign ej_valid[node_idx(x, y)]  = rt_out_valid[node_idx(x, y)][PORT_LOCAL];
                        assign rt_out_ready[node_idx(x, y)][PORT_LOCAL] = 1'b1;

                        // East neighbour, its port 3 faces us
                        if (x < MESH_X - 1) begin : gen_xp
                                assign rt_in_data[node_idx(x, y)][PORT_XP] =
                                        rt_out_data[node_idx(x + 1, y)][PORT_XM];
                                assign rt_in_valid[node_idx(x, y)][PORT_XP] =
                                        rt_out_valid[node_idx(x + 1, y)][PORT_XM];
                                assign rt_out_ready[node_idx(x, y)][PORT_XP] =
                                        rt_in_ready[node_idx(x + 1, y)][PORT_XM];
                        end else begin : gen_xp_edge
                                assign rt_in_data[node_idx(x, y)][PORT_XP]   = '0;
                                assign rt_in_valid[node_idx(x, y)][PORT_XP]  = 1'b0;
                                assign rt_out_ready[node_idx(x, y)][PORT_XP] = 1'b1;
                        end

                        // West neighbour
                        if (x > 0) begin : gen_xm
                                assign rt_in_data[node_idx(x, y)][PORT_XM] =
                                        rt_out_data[node_idx(x - 1, y)][PORT_XP];
                                assign rt_in_valid[node_idx(x, y)][PORT_XM] =
                                        rt_out_valid[node_idx(x - 1, y)][PORT_XP];
                                assign rt_out_ready[node_idx(x, y)][PORT_XM] =
                                        rt_in_ready[node_idx(x - 1, y)][PORT_XP];
                        end else begin : gen_xm_edge
                                assign rt_in_data[node_idx(x, y)][PORT_XM]   = '0;
                                assign rt_in_valid[node_idx(x, y)][PORT_XM]  = 1'b0;
                                assign rt_out_ready[node_idx(x, y)][PORT_XM] = 1'b1;
                        end

                        // Row below in index order, y+1
                        if (y < MESH_Y - 1) begin : gen_yp
                                assign rt_in_data[node_idx(x, y)][PORT_YP] =
                                        rt_out_data[node_idx(x, y + 1)][PORT_YM];
                                assign rt_in_valid[node_idx(x, y)][PORT_YP] =
                                        rt_out_valid[node_idx(x, y + 1)][PORT_YM];
                                assign rt_out_ready[node_idx(x, y)][PORT_YP] =
                                        rt_in_ready[node_idx(x, y + 1)][PORT_YM];
                        end else begin : gen_yp_edge
                                assign rt_in_data[node_idx(x, y)][PORT_YP]   = '0;
                                assign rt_in_valid[node_idx(x, y)][PORT_YP]  = 1'b0;
                                assign rt_out_ready[node_idx(x, y)][PORT_YP] = 1'b1;
                        end

                        // y-1 side
                        if (y > 0) begin : gen_ym
                                assign rt_in_data[node_idx(x, y)][PORT_YM] =
                                        rt_out_data[node_idx(x, y - 1)][PORT_YP];
                                assign rt_in_valid[node_idx(x, y)][PORT_YM] =
                                        rt_out_valid[node_idx(x, y - 1)][PORT_YP];
                                assign rt_out_ready[node_idx(x, y)][PORT_YM] =
                                        rt_in_ready[node_idx(x, y - 1)][PORT_YP];
                        end else begin : gen_ym_edge
                                assign rt_in_data[node_idx(x, y)][PORT_YM]   = '0;
                                assign rt_in_valid[node_idx(x, y)][PORT_YM]  = 1'b0;
                                assign rt_out_ready[node_idx(x, y)][PORT_YM] = 1'b1;
                        end

                        noc_router #(
                                .ROUTER_X ( x ),
                                .ROUTER_Y ( y )
                        ) router_i (
                                .clk       ( clk                          ),
                                .rst_n     ( rst_n                        ),
                                .in_data   ( rt_in_data[node_idx(x, y)]   ),
                                .in_valid  ( rt_in_valid[node_idx(x, y)]  ),
                                .in_ready  ( rt_in_ready[node_idx(x, y)]  ),
                                .out_data  ( rt_out_data[node_idx(x, y)]  ),
                                .out_valid ( rt_out_valid[node_idx(x, y)] ),
                                .out_ready ( rt_out_ready[node_idx(x, y)] )
                        );
                end
        end

endmodule

`default_nettype wire

/* noc_router.sv */
// ********************
// Mesh router
// ********************

`default_nettype none

module noc_router import noc_pkg::*; #(
        parameter int ROUTER_X = 0,
        parameter int ROUTER_Y = 0
) (
        input  logic  clk,
        input  logic  rst_n,

        // Input links with FIFO-not-full ready
        input  flit_t in_data   [PORT_NUM],
        input  logic  in_valid  [PORT_NUM],
        output logic  in_ready  [PORT_NUM],

        // Output links held until ready
        output flit_t out_data  [PORT_NUM],
        output logic  out_valid [PORT_NUM],
        input  logic  out_ready [PORT_NUM]
);

        flit_t head_data  [PORT_NUM];
        logic  head_valid [PORT_NUM];
        logic  fifo_push  [PORT_NUM];
        logic  fifo_pop   [PORT_NUM];

        logic                out_free  [PORT_NUM];
        logic                out_load  [PORT_NUM];
        logic [PORT_NUM-1:0] grant     [PORT_NUM];
        flit_t               xbar_data [PORT_NUM];

        // One input buffer per port
        for (genvar p = 0; p < PORT_NUM; p++) begin : gen_in
                // Flit crosses the link when both sides agree
                assign fifo_push[p] = in_valid[p] && in_ready[p];

                flit_fifo fifo_i (
                        .clk        ( clk           ),
                        .rst_n      ( rst_n         ),
                        .push       ( fifo_push[p]  ),
                        .push_data  ( in_data[p]    ),
                        .pop        ( fifo_pop[p]   ),
                        .head_data  ( head_data[p]  ),
                        .head_valid ( head_valid[p] ),
                        .ready      ( in_ready[p]   )
                );
        end

        switch_alloc #(
                .ROUTER_X ( ROUTER_X ),
                .ROUTER_Y ( ROUTER_Y )
        ) alloc_i (
                .clk        ( clk        ),
                .rst_n      ( rst_n      ),
                .head_data  ( head_data  ),
                .head_valid ( head_valid ),
                .out_free   ( out_free   ),
                .pop        ( fifo_pop   ),
                .grant      ( grant      )
        );

        // One-hot grant picks the head for each output
        always_comb begin
                for (int o = 0; o < PORT_NUM; o++) begin
                        xbar_data[o] = '0;
                        for (int i = 0; i < PORT_NUM; i++) begin
                                if (grant[o][i]) begin
                                        xbar_data[o] = head_data[i];
                                end
                        end
                end
        end

        // One output register per port
        for (genvar o = 0; o < PORT_NUM; o++) begin : gen_out
                // Free when empty or draining now
                assign out_free[o] = !out_valid[o] || out_ready[o];
                assign out_load[o] = |grant[o];

                always_ff @(posedge clk or negedge rst_n) begin
                        if (!rst_n) begin
                                out_valid[o] <= 1'b0;
                        end else if (out_load[o]) begin
                                out_valid[o] <= 1'b1;
                        end else if (out_ready[o]) begin
                                out_valid[o] <= 1'b0;
                        end
                end

                // Data follows the grant
                always_ff @(posedge clk) begin
                        if (out_load[o]) begin
                                out_data[o] <= xbar_data[o];
                        end
                end

                // Stalled flit holds until the neighbour takes it
                assert property (@(posedge clk) disable iff (!rst_n)
                        out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_data[o]));
        end

endmodule

`default_nettype wire

/* switch_alloc.sv */
// ********************
// XY route and switch allocator
// ********************

`default_nettype none

module switch_alloc import noc_pkg::*; #(
        parameter int ROUTER_X = 0,
        parameter int ROUTER_Y = 0
) (
        input  logic                clk,
        input  logic                rst_n,
        input  flit_t               head_data  [PORT_NUM],
        input  logic                head_valid [PORT_NUM],
        input  logic                out_free   [PORT_NUM],
        output logic                pop        [PORT_NUM],
        output logic [PORT_NUM-1:0] grant      [PORT_NUM]
);

        // Requested output per input head
        port_e route [PORT_NUM];

        // Request matrix, indexed [output][input]
        logic [PORT_NUM-1:0] req [PORT_NUM];

        // Round-robin state and the winner of this cycle
        logic [$clog2(PORT_NUM)-1:0] rr_ptr  [PORT_NUM];
        logic [$clog2(PORT_NUM)-1:0] win_idx [PORT_NUM];

        // Grants seen per input, for the checker
        logic [PORT_NUM-1:0] grant_col [PORT_NUM];

        // Dimension order, X first then Y
        always_comb begin
                for (int i = 0; i < PORT_NUM; i++) begin
                        if (head_data[i].dst_x > COORD_W'(ROUTER_X)) begin
                                route[i] = PORT_XP;
                        end else if (head_data[i].dst_x < COORD_W'(ROUTER_X)) begin
                                route[i] = PORT_XM;
                        end else if (head_data[i].dst_y > COORD_W'(ROUTER_Y)) begin
                                route[i] = PORT_YP;
                        end else if (head_data[i].dst_y < COORD_W'(ROUTER_Y)) begin
                                route[i] = PORT_YM;
                        end else begin
                                route[i] = PORT_LOCAL;
                        end
                end
        end

        // Only valid heads raise a request
        always_comb begin
                for (int o = 0; o < PORT_NUM; o++) begin
                        req[o] = '0;
                end
                for (int i = 0; i < PORT_NUM; i++) begin
                        if (head_valid[i]) begin
                                req[route[i]][i] = 1'b1;
                        end
                end
        end

        // First requester at or after the pointer wins
        always_comb begin
                int   idx;
                logic found;

                for (int o = 0; o < PORT_NUM; o++) begin
                        grant[o]   = '0;
                        win_idx[o] = '0;
                        found      = 1'b0;
                        for (int k = 0; k < PORT_NUM; k++) begin
                                idx = (int'(rr_ptr[o]) + k) % PORT_NUM;
                                if (!found && req[o][idx] && out_free[o]) begin
                                        grant[o][idx] = 1'b1;
                                        win_idx[o]    = idx[$clog2(PORT_NUM)-1:0];
                                        found         = 1'b1;
                                end
                        end
                end
        end

        // Pop every granted head
        always_comb begin
                for (int i = 0; i < PORT_NUM; i++) begin
                        grant_col[i] = '0;
                        for (int o = 0; o < PORT_NUM; o++) begin
                                grant_col[i][o] = grant[o][i];
                        end
                        pop[i] = |grant_col[i];
                end
        end

        // Pointer moves one past the last winner
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int o = 0; o < PORT_NUM; o++) begin
                                rr_ptr[o] <= '0;
                        end
                end else begin
                        for (int o = 0; o < PORT_NUM; o++) begin
                                if (|grant[o]) begin
                                        rr_ptr[o] <= (int'(win_idx[o]) == PORT_NUM - 1) ?
                                                     '0 : win_idx[o] + 1'b1;
                                end
                        end
                end
        end

        for (genvar p = 0; p < PORT_NUM; p++) begin : gen_chk
                // One winner per output
                assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant[p]));
                // A head leaves through one output at most
                assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant_col[p]));
        end

endmodule

`default_nettype wire

/* flit_fifo.sv */
// ********************
// Router input FIFO
// ********************

`default_nettype none

module flit_fifo import noc_pkg::*; (
        input  logic  clk,
        input  logic  rst_n,
        input  logic  push,
        input  flit_t push_data,
        input  logic  pop,
        output flit_t head_data,
        output logic  head_valid,
        output logic  ready
);

        // Entry storage
        flit_t mem [FIFO_DEPTH];

        logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
        logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
        logic [$clog2(FIFO_DEPTH+1)-1:0] count;

        always_ff @(posedge clk) begin
                if (push) begin
                        mem[wr_ptr] <= push_data;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        // Circular pointers wrap at depth
                        if (push) begin
                                wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
                        end
                        // Simultaneous push and pop leaves count alone
                        case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // Head visible the cycle after its push
        assign head_data  = mem[rd_ptr];
        assign head_valid = (count != '0);

        // Link ready from registered count only
        assign ready = (int'(count) < FIFO_DEPTH);

        // Upstream must respect ready
        assert property (@(posedge clk) disable iff (!rst_n) push |-> ready);

        // Allocator only pops a valid head
        assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_valid);

endmodule

`default_nettype wire

/* noc_pkg.sv */
// ********************
// NoC mesh definitions
// ********************

`default_nettype none

package noc_pkg;

        // Mesh geometry
        localparam int MESH_X   = 3;
        localparam int MESH_Y   = 3;
        localparam int NODE_NUM = MESH_X * MESH_Y;

        // Flit layout, coordinates on top
        localparam int FLIT_W    = 32;
        localparam int COORD_W   = 2;
        localparam int PAYLOAD_W = FLIT_W - 2 * COORD_W;

        // Router ports, four neighbours plus the local node
        localparam int PORT_NUM = 5;

        // Entries per input buffer
        localparam int FIFO_DEPTH = 4;

        // Port numbering as seen from inside a router
        typedef enum logic [2:0] {
                PORT_YM    = 3'd0,
                PORT_XP    = 3'd1,
                PORT_YP    = 3'd2,
                PORT_XM    = 3'd3,
                PORT_LOCAL = 3'd4
        } port_e;

        // Single-flit packet
        typedef struct packed {
                logic [COORD_W-1:0]   dst_x;
                logic [COORD_W-1:0]   dst_y;
                logic [PAYLOAD_W-1:0] payload;
        } flit_t;

        // Node index from grid position, row major
        function automatic int node_idx(input int x, input int y);
                return y * MESH_X + x;
        endfunction

endpackage

`default_nettype wire
